/* Bender.yml */
package:
  name: serial_slave

sources:
  - files:
      - hw/serial_slave_pkg.sv
      - hw/serial_slave_ifs.sv
      - hw/ctrl_frame_rx.sv
      - hw/slave_ctrl_fsm.sv
      - hw/serial_data_path.sv
      - hw/slave_ram.sv
      - hw/serial_slave.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_serial_slave.sv

/* dv/serial_slave_vectors.svh */
// columns: op, sid, start bits, burst, address, word count, data words 0 to 3, valid gaps
// reads use only the header columns, their data comes from the reference memory

localparam logic WR = 1'b1;
localparam logic RD = 1'b0;

localparam int NUM_TXNS = 18;

typedef struct packed {
    logic        is_write;
    sid_t        sid;
    logic [2:0]  start;
    logic        burst;
    addr_t       addr;
    logic [2:0]  count;
    data_t [3:0] words;
    logic        gaps;
} txn_t;

txn_t txn_table [NUM_TXNS];

function automatic txn_t make_txn(
    input logic       is_write,
    input sid_t       sid,
    input logic [2:0] start,
    input logic       burst,
    input addr_t      addr,
    input int         count,
    input data_t      w0,
    input data_t      w1,
    input data_t      w2,
    input data_t      w3,
    input logic       gaps
);
    txn_t t;
    t.is_write = is_write;
    t.sid      = sid;
    t.start    = start;
    t.burst    = burst;
    t.addr     = addr;
    t.count    = 3'(count);
    t.words[0] = w0;
    t.words[1] = w1;
    t.words[2] = w2;
    t.words[3] = w3;
    t.gaps     = gaps;
    return t;
endfunction

task automatic load_table();
    // single write, then read it back
    txn_table[0]  = make_txn(WR, 2'd1, 3'b111, 1'b0, 4'd3,  1, 16'hA5C3, '0, '0, '0, 1'b0);
    txn_table[1]  = make_txn(RD, 2'd1, 3'b111, 1'b0, 4'd3,  1, '0, '0, '0, '0, 1'b0);
    // four word burst with stalls
    txn_table[2]  = make_txn(WR, 2'd1, 3'b111, 1'b1, 4'd6,  4,
                             16'h1234, 16'h5678, 16'h9ABC, 16'hDEF0, 1'b1);
    txn_table[3]  = make_txn(RD, 2'd1, 3'b111, 1'b0, 4'd6,  1, '0, '0, '0, '0, 1'b0);
    txn_table[4]  = make_txn(RD, 2'd1, 3'b111, 1'b0, 4'd7,  1, '0, '0, '0, '0, 1'b0);
    txn_table[5]  = make_txn(RD, 2'd1, 3'b111, 1'b0, 4'd8,  1, '0, '0, '0, '0, 1'b0);
    txn_table[6]  = make_txn(RD, 2'd1, 3'b111, 1'b0, 4'd9,  1, '0, '0, '0, '0, 1'b0);
    // burst from the top address wraps to 0
    txn_table[7]  = make_txn(WR, 2'd1, 3'b111, 1'b1, 4'd15, 2,
                             16'h0F0F, 16'hC0DE, '0, '0, 1'b1);
    txn_table[8]  = make_txn(RD, 2'd1, 3'b111, 1'b0, 4'd0,  1, '0, '0, '0, '0, 1'b0);
    txn_table[9]  = make_txn(RD, 2'd1, 3'b111, 1'b0, 4'd15, 1, '0, '0, '0, '0, 1'b0);
    // foreign id, bad start bits, foreign burst and foreign read
    txn_table[10] = make_txn(WR, 2'd2, 3'b111, 1'b0, 4'd3,  1, 16'hFFFF, '0, '0, '0, 1'b0);
    txn_table[11] = make_txn(WR, 2'd1, 3'b101, 1'b0, 4'd3,  1, 16'h0000, '0, '0, '0, 1'b0);
    txn_table[12] = make_txn(WR, 2'd3, 3'b111, 1'b1, 4'd7,  2,
                             16'hFFFF, 16'h0000, '0, '0, 1'b1);
    txn_table[13] = make_txn(RD, 2'd2, 3'b111, 1'b0, 4'd6,  1, '0, '0, '0, '0, 1'b0);
    txn_table[14] = make_txn(RD, 2'd1, 3'b111, 1'b0, 4'd3,  1, '0, '0, '0, '0, 1'b0);
    txn_table[15] = make_txn(RD, 2'd1, 3'b111, 1'b0, 4'd7,  1, '0, '0, '0, '0, 1'b0);
    // overwrite with stalls
    txn_table[16] = make_txn(WR, 2'd1, 3'b111, 1'b0, 4'd0,  1, 16'h8001, '0, '0, '0, 1'b1);
    txn_table[17] = make_txn(RD, 2'd1, 3'b111, 1'b0, 4'd0,  1, '0, '0, '0, '0, 1'b0);
endtask

/* dv/tb_serial_slave.sv */
`timescale 1ns/1ps

module tb_serial_slave;
    import serial_slave_pkg::*;

    localparam int   CLK_PERIOD  = 20;
    localparam int   DRIVE_DELAY = 2;
    localparam sid_t OWN_ID      = 2'd1;

    `include "serial_slave_vectors.svh"

    // every bit may stall up to 3 cycles, hence the factor 4
    localparam int WATCHDOG_CYCLES = NUM_TXNS * (FRAME_BITS + 4 * DATA_WIDTH * 4 + 20);

    logic clk;
    logic rstN;
    logic control;
    logic wr_data;
    logic valid;
    logic last;
    logic rd_data;
    logic ready;

    data_t  ref_mem [ADDR_DEPTH];
    logic   written [ADDR_DEPTH];
    integer seed;
    int     err_count;
    int     check_count;

    serial_slave #(
        .SLAVE_ID (OWN_ID)
    ) DUT (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wr_data (wr_data),
        .valid   (valid),
        .last    (last),
        .rd_data (rd_data),
        .ready   (ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES + 4) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("ERR %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("ERR %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    // moves to the drive point just after the next rising edge
    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    function automatic logic is_hit(input txn_t t);
        return (t.start == START_CODE) && (t.sid == OWN_ID);
    endfunction

    // control frame, MSB first
    task automatic send_frame(input txn_t t);
        logic [FRAME_BITS-1:0] bits;
        bits = {t.start, t.sid, t.is_write, t.burst, t.addr};
        for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            control = bits[i];
            step();
        end
        control = 1'b0;
    endtask

    task automatic drive_bit(input logic bit_val, input logic last_val, input logic gaps);
        int gap;
        int r;
        gap = 0;
        r = 0;
        if (gaps) begin
            r = $random(seed);
            // about one bit in four waits up to 3 idle cycles
            if (r[3:2] == 2'b00) begin
                gap = r[1:0];
            end
        end
        repeat (gap) begin
            valid   = 1'b0;
            wr_data = r[4];
            step();
            check_bit("ready", 1'b1, ready);
        end
        valid   = 1'b1;
        wr_data = bit_val;
        last    = last_val;
        step();
        check_bit("ready", 1'b1, ready);
        check_bit("rd_data", 1'b0, rd_data);
        valid   = 1'b0;
        last    = 1'b0;
        wr_data = 1'b0;
    endtask

    task automatic do_write(input txn_t t);
        addr_t a;
        logic  hit;
        hit = is_hit(t);
        send_frame(t);
        step();
        if (hit) begin
            check_bit("ready", 1'b1, ready);
        end else begin
            // a missed frame releases ready one cycle later
            check_bit("ready", 1'b0, ready);
            step();
            check_bit("ready", 1'b1, ready);
        end
        for (int w = 0; w < t.count; w++) begin
            for (int b = DATA_WIDTH - 1; b >= 0; b--) begin
                drive_bit(t.words[w][b], (w == t.count - 1) && (b == 0), t.gaps);
            end
        end
        if (hit) begin
            a = t.addr;
            for (int w = 0; w < t.count; w++) begin
                ref_mem[a] = t.words[w];
                written[a] = 1'b1;
                a = addr_t'((int'(a) + 1) % ADDR_DEPTH);
            end
        end
    endtask

    task automatic do_read(input txn_t t);
        data_t got;
        send_frame(t);
        step();
        check_bit("ready", 1'b0, ready);
        check_bit("rd_data", 1'b0, rd_data);
        step();
        if (!is_hit(t)) begin
            check_bit("ready", 1'b1, ready);
        end else begin
            check_bit("ready", 1'b0, ready);
            check_bit("rd_data", 1'b0, rd_data);
            // word appears 3 cycles after the last frame bit
            for (int b = DATA_WIDTH - 1; b >= 0; b--) begin
                step();
                got[b] = rd_data;
                check_bit("ready", 1'b0, ready);
            end
            step();
            check_bit("ready", 1'b1, ready);
            if (!written[t.addr]) begin
                err_count++;
                $display("read of address %0d that no write has set", t.addr);
            end else begin
                check_data("rd_data", ref_mem[t.addr], got);
            end
        end
        check_bit("rd_data", 1'b0, rd_data);
    endtask

    initial begin
        seed        = 32'h9e10;
        err_count   = 0;
        check_count = 0;
        rstN        = 1'b0;
        control     = 1'b0;
        wr_data     = 1'b0;
        valid       = 1'b0;
        last        = 1'b0;
        for (int i = 0; i < ADDR_DEPTH; i++) begin
            written[i] = 1'b0;
        end
        load_table();
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rstN = 1'b1;
        check_bit("ready", 1'b1, ready);
        check_bit("rd_data", 1'b0, rd_data);
        step();
        for (int i = 0; i < NUM_TXNS; i++) begin
            if (txn_table[i].is_write) begin
                do_write(txn_table[i]);
            end else begin
                do_read(txn_table[i]);
            end
            step();
            check_bit("ready", 1'b1, ready);
            check_bit("rd_data", 1'b0, rd_data);
        end
        $display("checks: %0d errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* hw/ctrl_frame_rx.sv */
`timescale 1ns/1ps

module ctrl_frame_rx #(
    parameter serial_slave_pkg::sid_t SLAVE_ID = 1
) (
    input logic  clk,
    input logic  rstN,
    input logic  control,
    input logic  busy,
    frame_if.rx  frame
);
    import serial_slave_pkg::*;

    ctrl_word_u                 shift_word;
    ctrl_word_u                 next_word;
    logic [FRAME_CNT_WIDTH-1:0] frame_cnt;
    logic                       start_frame;
    logic                       shifting;
    logic                       last_bit;

    // a frame opens on the first high control bit while the FSM is free
    assign start_frame = !busy && (frame_cnt == '0) && control;
    assign shifting    = start_frame ||
                         ((frame_cnt != '0) && (frame_cnt != FRAME_CNT_WIDTH'(FRAME_BITS)));
    assign last_bit    = (frame_cnt == FRAME_CNT_WIDTH'(FRAME_BITS - 1));

    assign next_word.raw = {shift_word.raw[FRAME_BITS-2:0], control};

    // counter parks at FRAME_BITS for one cycle, which is the done pulse
    assign frame.frame_done = (frame_cnt == FRAME_CNT_WIDTH'(FRAME_BITS));
    assign frame.active     = (frame_cnt != '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            frame_cnt <= '0;
            frame.hit <= 1'b0;
        end else begin
            if (frame.frame_done) begin
                frame_cnt <= '0;
            end else if (shifting) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            if (last_bit) begin
                frame.hit <= (next_word.fields.start == START_CODE) &&
                             (next_word.fields.sid == SLAVE_ID);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (shifting) begin
            shift_word <= next_word;
        end
        // fields hold until the next frame completes
        if (last_bit) begin
            frame.write   <= next_word.fields.write;
            frame.burst   <= next_word.fields.burst;
            frame.address <= next_word.fields.address;
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (!rstN)
        frame.frame_done |=> !frame.frame_done);

    a_cnt_range: assert property (@(posedge clk) disable iff (!rstN)
        frame_cnt <= FRAME_CNT_WIDTH'(FRAME_BITS));

endmodule

/* hw/serial_data_path.sv */
`timescale 1ns/1ps

module serial_data_path (
    input  logic  clk,
    input  logic  rstN,
    input  logic  wr_data,
    input  logic  rd_load,
    input  logic  rd_shift,
    input  logic  wr_shift,
    output logic  rd_data,
    output logic  word_done,
    mem_if.data   mem
);
    import serial_slave_pkg::*;

    data_t                    wr_q;
    data_t                    rd_q;
    logic [BIT_CNT_WIDTH-1:0] bit_cnt;
    logic                     shift_en;

    assign shift_en = rd_shift | wr_shift;

    // high while the current shift is the last one of the word
    assign word_done = (bit_cnt == BIT_CNT_WIDTH'(DATA_WIDTH - 1));

    // next write word, so the RAM sees all bits on the final edge
    assign mem.wdata = {wr_q[DATA_WIDTH-2:0], wr_data};

    // zeros shift in behind the word, so rd_data idles low
    assign rd_data = rd_q[DATA_WIDTH-1];

    always_ff @(posedge clk) begin
        if (wr_shift) begin
            wr_q <= mem.wdata;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rd_q <= '0;
        end else if (rd_load) begin
            rd_q <= mem.rdata;
        end else if (rd_shift) begin
            rd_q <= {rd_q[DATA_WIDTH-2:0], 1'b0};
        end
    end

    // one counter serves both directions, only one is ever active
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt <= '0;
        end else if (rd_load) begin
            bit_cnt <= '0;
        end else if (shift_en) begin
            if (word_done) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    a_cnt_range: assert property (@(posedge clk) disable iff (!rstN)
        bit_cnt < BIT_CNT_WIDTH'(DATA_WIDTH));

endmodule

/* hw/serial_slave.sv */
`timescale 1ns/1ps

module serial_slave #(
    parameter serial_slave_pkg::sid_t SLAVE_ID = 1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wr_data,
    input  logic valid,
    input  logic last,
    output logic rd_data,
    output logic ready
);

    logic busy;
    logic rd_load;
    logic rd_shift;
    logic wr_shift;
    logic word_done;

    frame_if frame ();
    mem_if   mem ();

    ctrl_frame_rx #(
        .SLAVE_ID (SLAVE_ID)
    ) u_frame_rx (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .busy    (busy),
        .frame   (frame.rx)
    );

    slave_ctrl_fsm u_ctrl (
        .clk       (clk),
        .rstN      (rstN),
        .valid     (valid),
        .last      (last),
        .word_done (word_done),
        .busy      (busy),
        .ready     (ready),
        .rd_load   (rd_load),
        .rd_shift  (rd_shift),
        .wr_shift  (wr_shift),
        .frame     (frame.fsm),
        .mem       (mem.ctrl)
    );

    serial_data_path u_data (
        .clk       (clk),
        .rstN      (rstN),
        .wr_data   (wr_data),
        .rd_load   (rd_load),
        .rd_shift  (rd_shift),
        .wr_shift  (wr_shift),
        .rd_data   (rd_data),
        .word_done (word_done),
        .mem       (mem.data)
    );

    slave_ram u_ram (
        .clk (clk),
        .mem (mem.ram)
    );

endmodule

/* hw/serial_slave_ifs.sv */
`timescale 1ns/1ps

// decoded control frame, from the frame receiver to the transaction FSM
interface frame_if;
    import serial_slave_pkg::*;

    // one-cycle pulse once the last frame bit is in
    logic  frame_done;
    // high while a frame is being shifted in
    logic  active;
    // start bits and id both matched
    logic  hit;
    logic  write;
    logic  burst;
    addr_t address;

    modport rx (
        output frame_done,
        output active,
        output hit,
        output write,
        output burst,
        output address
    );

    modport fsm (
        input frame_done,
        input active,
        input hit,
        input write,
        input burst,
        input address
    );
endinterface

// single-port RAM access shared by the FSM, data path and memory
interface mem_if;
    import serial_slave_pkg::*;

    addr_t addr;
    logic  we;
    data_t wdata;
    data_t rdata;

    modport ctrl (output addr, output we);
    modport data (output wdata, input rdata);
    modport ram  (input addr, input we, input wdata, output rdata);
endinterface

/* hw/serial_slave_pkg.sv */
package serial_slave_pkg;

    // bus and memory geometry
    localparam int DATA_WIDTH  = 16;
    localparam int ADDR_DEPTH  = 16;
    localparam int ADDR_WIDTH  = $clog2(ADDR_DEPTH);
    localparam int SLAVE_COUNT = 3;
    // ids run from 1 to SLAVE_COUNT, so 0 must stay free
    localparam int SID_WIDTH   = $clog2(SLAVE_COUNT + 1);

    // control frame is start | sid | write | burst | address, MSB first
    localparam logic [2:0] START_CODE = 3'b111;
    localparam int FRAME_BITS      = 3 + SID_WIDTH + 2 + ADDR_WIDTH;
    localparam int FRAME_CNT_WIDTH = $clog2(FRAME_BITS + 1);
    localparam int BIT_CNT_WIDTH   = $clog2(DATA_WIDTH + 1);

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [SID_WIDTH-1:0]  sid_t;

    // write is 1 for a write and 0 for a read
    typedef struct packed {
        logic [2:0] start;
        sid_t       sid;
        logic       write;
        logic       burst;
        addr_t      address;
    } ctrl_frame_t;

    // filled as a plain shift word, read back as fields
    typedef union packed {
        logic [FRAME_BITS-1:0] raw;
        ctrl_frame_t           fields;
    } ctrl_word_u;

endpackage

/* hw/slave_ctrl_fsm.sv */
`timescale 1ns/1ps

module slave_ctrl_fsm (
    input  logic  clk,
    input  logic  rstN,
    input  logic  valid,
    input  logic  last,
    input  logic  word_done,
    output logic  busy,
    output logic  ready,
    output logic  rd_load,
    output logic  rd_shift,
    output logic  wr_shift,
    frame_if.fsm  frame,
    mem_if.ctrl   mem
);
    import serial_slave_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        READ_FETCH,
        READ_LOAD,
        READ_SHIFT,
        WRITE
    } state_t;

    state_t state;
    addr_t  next_addr;
    logic   burst_more;

    // receiver may only open a frame while nothing is in flight
    assign busy = (state != IDLE);

    assign rd_load  = (state == READ_LOAD);
    assign rd_shift = (state == READ_SHIFT);
    // valid low simply holds the write shift register
    assign wr_shift = (state == WRITE) && valid;

    // word_done here means this bit completes the word
    assign mem.we = wr_shift && word_done;

    assign burst_more = frame.burst && !last;
    assign next_addr  = (mem.addr == addr_t'(ADDR_DEPTH - 1)) ? '0 : mem.addr + 1'b1;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
            ready <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (frame.active) begin
                        state <= DECODE;
                        ready <= 1'b0;
                    end else begin
                        ready <= 1'b1;
                    end
                end
                DECODE: begin
                    // wait for the receiver to finish and branch on the fields
                    if (frame.frame_done) begin
                        if (!frame.hit) begin
                            state <= IDLE;
                        end else if (frame.write) begin
                            state <= WRITE;
                            ready <= 1'b1;
                        end else begin
                            state <= READ_FETCH;
                        end
                    end
                end
                READ_FETCH: begin
                    // RAM registers rdata at this edge
                    state <= READ_LOAD;
                end
                READ_LOAD: begin
                    state <= READ_SHIFT;
                end
                READ_SHIFT: begin
                    if (word_done) begin
                        state <= IDLE;
                        ready <= 1'b1;
                    end
                end
                WRITE: begin
                    if (mem.we && !burst_more) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // word address loads from a matching frame and steps once per burst word
    always_ff @(posedge clk) begin
        if ((state == DECODE) && frame.frame_done && frame.hit) begin
            mem.addr <= frame.address;
        end else if (mem.we && burst_more) begin
            mem.addr <= next_addr;
        end
    end

    // a RAM write needs a matching write frame that still holds its fields
    a_we_in_write: assert property (@(posedge clk) disable iff (!rstN)
        mem.we |-> (state == WRITE) && frame.hit && frame.write);

    a_shift_excl: assert property (@(posedge clk) disable iff (!rstN)
        !(rd_shift && wr_shift));

endmodule

/* hw/slave_ram.sv */
`timescale 1ns/1ps

module slave_ram (
    input logic  clk,
    mem_if.ram   mem
);
    import serial_slave_pkg::*;

    // contents are undefined until written
    data_t mem_q [ADDR_DEPTH];

    always_ff @(posedge clk) begin
        if (mem.we) begin
            mem_q[mem.addr] <= mem.wdata;
        end
    end

    // registered read, one cycle after addr
    always_ff @(posedge clk) begin
        mem.rdata <= mem_q[mem.addr];
    end

endmodule

/* serial_slave.f */
+incdir+dv
hw/serial_slave_pkg.sv
hw/serial_slave_ifs.sv
hw/ctrl_frame_rx.sv
hw/slave_ctrl_fsm.sv
hw/serial_data_path.sv
hw/slave_ram.sv
hw/serial_slave.sv
dv/tb_serial_slave.sv
